// ==== common/stream_defs.svh ====
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

// width of tdata, a whole number of bytes
`define STREAM_DATA_BITS 64
`define STREAM_KEEP_BITS (`STREAM_DATA_BITS / 8)

// completed-packet counter, wraps
`define STREAM_CNT_BITS 16

`endif

// ==== common/stream_pkg.sv ====
package stream_pkg;

	// transform applied to every beat of a packet, picked on the first beat
	typedef enum logic [1:0] {
		OP_PASS     = 2'd0,
		OP_INVERT   = 2'd1,
		OP_BYTE_REV = 2'd2,
		OP_INCR     = 2'd3
	} stream_op_e;

	// ST_IN_PKT means the opcode of the current packet is held
	typedef enum logic [0:0] {
		ST_IDLE   = 1'b0,
		ST_IN_PKT = 1'b1
	} pkt_state_e;

endpackage

// ==== verilog/axis_reg_slice.sv ====
`timescale 1ns/1ps
`include "stream_defs.svh"

module axis_reg_slice #(
	parameter integer data_bits = `STREAM_DATA_BITS
) (
	input  logic                   aclk,
	input  logic                   aresetn,

	input  logic                   in_tvalid,
	output logic                   in_tready,
	input  logic [data_bits-1:0]   in_tdata,
	input  logic [data_bits/8-1:0] in_tkeep,
	input  logic                   in_tlast,

	output logic                   out_tvalid,
	input  logic                   out_tready,
	output logic [data_bits-1:0]   out_tdata,
	output logic [data_bits/8-1:0] out_tkeep,
	output logic                   out_tlast
);

	localparam integer keep_bits = data_bits / 8;

	logic                 ready_q, ready_d;
	logic                 out_valid_q, out_valid_d;
	logic [data_bits-1:0] out_data_q, out_data_d;
	logic [keep_bits-1:0] out_keep_q, out_keep_d;
	logic                 out_last_q, out_last_d;
	logic                 skid_valid_q, skid_valid_d;
	logic [data_bits-1:0] skid_data_q, skid_data_d;
	logic [keep_bits-1:0] skid_keep_q, skid_keep_d;
	logic                 skid_last_q, skid_last_d;

	// stay ready unless the skid is full or about to fill while the output stalls
	assign ready_d = out_tready || (!skid_valid_q && (!out_valid_q || !in_tvalid));

	always_comb begin
		out_valid_d  = out_valid_q;
		out_data_d   = out_data_q;
		out_keep_d   = out_keep_q;
		out_last_d   = out_last_q;
		skid_valid_d = skid_valid_q;
		skid_data_d  = skid_data_q;
		skid_keep_d  = skid_keep_q;
		skid_last_d  = skid_last_q;

		if (ready_q) begin
			if (out_tready || !out_valid_q) begin
				out_valid_d = in_tvalid;
				out_data_d  = in_tdata;
				out_keep_d  = in_tkeep;
				out_last_d  = in_tlast;
			end else begin
				// output is held, the incoming beat parks in the skid register
				skid_valid_d = in_tvalid;
				skid_data_d  = in_tdata;
				skid_keep_d  = in_tkeep;
				skid_last_d  = in_tlast;
			end
		end else if (out_tready) begin
			out_valid_d  = skid_valid_q;
			out_data_d   = skid_data_q;
			out_keep_d   = skid_keep_q;
			out_last_d   = skid_last_q;
			skid_valid_d = 1'b0;
		end
	end

	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn) begin
			ready_q      <= 1'b0;
			out_valid_q  <= 1'b0;
			skid_valid_q <= 1'b0;
		end else begin
			ready_q      <= ready_d;
			out_valid_q  <= out_valid_d;
			skid_valid_q <= skid_valid_d;
		end
	end

	always_ff @(posedge aclk) begin
		out_data_q  <= out_data_d;
		out_keep_q  <= out_keep_d;
		out_last_q  <= out_last_d;
		skid_data_q <= skid_data_d;
		skid_keep_q <= skid_keep_d;
		skid_last_q <= skid_last_d;
	end

	assign in_tready  = ready_q;
	assign out_tvalid = out_valid_q;
	assign out_tdata  = out_data_q;
	assign out_tkeep  = out_keep_q;
	assign out_tlast  = out_last_q;

	// a stalled output beat must not change or vanish before it is taken
	a_out_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		(out_tvalid && !out_tready) |=>
			(out_tvalid && $stable(out_tdata) && $stable(out_tkeep) && $stable(out_tlast)));

endmodule

// ==== verilog/stream_op_unit.sv ====
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_op_unit (
	input  logic                           aclk,
	input  logic                           aresetn,

	input  stream_pkg::stream_op_e         op,

	input  logic                           in_tvalid,
	output logic                           in_tready,
	input  logic [`STREAM_DATA_BITS-1:0]   in_tdata,
	input  logic [`STREAM_KEEP_BITS-1:0]   in_tkeep,
	input  logic                           in_tlast,

	output logic                           out_tvalid,
	input  logic                           out_tready,
	output logic [`STREAM_DATA_BITS-1:0]   out_tdata,
	output logic [`STREAM_KEEP_BITS-1:0]   out_tkeep,
	output logic                           out_tlast,

	output logic [`STREAM_CNT_BITS-1:0]    pkt_count
);

	import stream_pkg::*;

	pkt_state_e                  state_q;
	stream_op_e                  op_q;
	stream_op_e                  cur_op;
	logic                        xfer;
	logic [`STREAM_CNT_BITS-1:0] count_q;

	function automatic logic [`STREAM_DATA_BITS-1:0] byte_rev(
		input logic [`STREAM_DATA_BITS-1:0] word
	);
		logic [`STREAM_DATA_BITS-1:0] res;
		res = '0;
		for (int i = 0; i < `STREAM_KEEP_BITS; i++) begin
			res[8*i +: 8] = word[8*(`STREAM_KEEP_BITS-1-i) +: 8];
		end
		return res;
	endfunction

	// no storage on the data path, the handshake passes straight through
	assign in_tready  = out_tready;
	assign out_tvalid = in_tvalid;
	assign out_tkeep  = in_tkeep;
	assign out_tlast  = in_tlast;
	assign xfer       = in_tvalid && out_tready;

	// the first beat takes op directly, later beats use the latched copy
	assign cur_op = (state_q == ST_IDLE) ? op : op_q;

	always_comb begin
		case (cur_op)
			OP_INVERT:   out_tdata = ~in_tdata;
			OP_BYTE_REV: out_tdata = byte_rev(in_tdata);
			OP_INCR:     out_tdata = in_tdata + 1'b1;
			default:     out_tdata = in_tdata;
		endcase
	end

	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn) begin
			state_q <= ST_IDLE;
			op_q    <= OP_PASS;
			count_q <= '0;
		end else if (xfer) begin
			if (state_q == ST_IDLE) begin
				op_q <= op;
			end
			if (in_tlast) begin
				state_q <= ST_IDLE;
				count_q <= count_q + 1'b1;
			end else begin
				state_q <= ST_IN_PKT;
			end
		end
	end

	assign pkt_count = count_q;

	// a packet only opens on a taken beat that is not its last
	a_enter_pkt: assert property (@(posedge aclk) disable iff (!aresetn)
		(state_q == ST_IDLE && !(xfer && !in_tlast)) |=> (state_q == ST_IDLE));

endmodule

// ==== verilog/stream_path.sv ====
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_path (
	input  logic                           aclk,
	input  logic                           aresetn,

	input  stream_pkg::stream_op_e         op,

	input  logic                           s_tvalid,
	output logic                           s_tready,
	input  logic [`STREAM_DATA_BITS-1:0]   s_tdata,
	input  logic [`STREAM_KEEP_BITS-1:0]   s_tkeep,
	input  logic                           s_tlast,

	output logic                           m_tvalid,
	input  logic                           m_tready,
	output logic [`STREAM_DATA_BITS-1:0]   m_tdata,
	output logic [`STREAM_KEEP_BITS-1:0]   m_tkeep,
	output logic                           m_tlast,

	output logic [`STREAM_CNT_BITS-1:0]    pkt_count
);

	// input slice to op unit
	logic                         a_tvalid;
	logic                         a_tready;
	logic [`STREAM_DATA_BITS-1:0] a_tdata;
	logic [`STREAM_KEEP_BITS-1:0] a_tkeep;
	logic                         a_tlast;

	// op unit to output slice
	logic                         b_tvalid;
	logic                         b_tready;
	logic [`STREAM_DATA_BITS-1:0] b_tdata;
	logic [`STREAM_KEEP_BITS-1:0] b_tkeep;
	logic                         b_tlast;

	axis_reg_slice #(
		.data_bits(`STREAM_DATA_BITS)
	) i_in_slice (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.in_tvalid (s_tvalid),
		.in_tready (s_tready),
		.in_tdata  (s_tdata),
		.in_tkeep  (s_tkeep),
		.in_tlast  (s_tlast),
		.out_tvalid(a_tvalid),
		.out_tready(a_tready),
		.out_tdata (a_tdata),
		.out_tkeep (a_tkeep),
		.out_tlast (a_tlast)
	);

	stream_op_unit i_op_unit (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.op        (op),
		.in_tvalid (a_tvalid),
		.in_tready (a_tready),
		.in_tdata  (a_tdata),
		.in_tkeep  (a_tkeep),
		.in_tlast  (a_tlast),
		.out_tvalid(b_tvalid),
		.out_tready(b_tready),
		.out_tdata (b_tdata),
		.out_tkeep (b_tkeep),
		.out_tlast (b_tlast),
		.pkt_count (pkt_count)
	);

	axis_reg_slice #(
		.data_bits(`STREAM_DATA_BITS)
	) i_out_slice (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.in_tvalid (b_tvalid),
		.in_tready (b_tready),
		.in_tdata  (b_tdata),
		.in_tkeep  (b_tkeep),
		.in_tlast  (b_tlast),
		.out_tvalid(m_tvalid),
		.out_tready(m_tready),
		.out_tdata (m_tdata),
		.out_tkeep (m_tkeep),
		.out_tlast (m_tlast)
	);

endmodule

// ==== verif/stream_path_checker.sv ====
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_path_checker (
	input  logic                         aclk,
	input  logic                         aresetn,
	input  stream_pkg::stream_op_e       op,
	input  logic                         s_tvalid,
	input  logic                         s_tready,
	input  logic [`STREAM_DATA_BITS-1:0] s_tdata,
	input  logic [`STREAM_KEEP_BITS-1:0] s_tkeep,
	input  logic                         s_tlast,
	input  logic                         m_tvalid,
	input  logic                         m_tready,
	input  logic [`STREAM_DATA_BITS-1:0] m_tdata,
	input  logic [`STREAM_KEEP_BITS-1:0] m_tkeep,
	input  logic                         m_tlast,
	input  logic [`STREAM_CNT_BITS-1:0]  pkt_count,
	input  logic [7:0]                   test_id,
	input  logic                         steady,
	input  logic                         done,
	output int                           errors,
	output int                           beats_out,
	output int                           pending
);

	import stream_pkg::*;

	logic [`STREAM_DATA_BITS-1:0] exp_data_q[$];
	logic [`STREAM_KEEP_BITS-1:0] exp_keep_q[$];
	logic                         exp_last_q[$];
	logic [7:0]                   id_q[$];
	logic                         steady_q[$];
	int                           cycle_q[$];
	stream_op_e                   pkt_op;
	logic                         in_pkt;
	logic                         held;
	logic [`STREAM_DATA_BITS-1:0] held_data;
	logic [7:0]                   cur_id;
	int                           cycle;
	int                           tlast_out;
	int                           stall_cnt;
	int                           test_beats;
	int                           test_errs;
	logic                         prev_steady;
	int                           prev_cycle;

	// expected output word from the opcode rules
	function automatic logic [`STREAM_DATA_BITS-1:0] expect_word(
		input stream_op_e                   code,
		input logic [`STREAM_DATA_BITS-1:0] w
	);
		logic [`STREAM_DATA_BITS-1:0] r;
		r = '0;
		case (code)
			OP_INVERT: r = ~w;
			OP_INCR:   r = w + 64'd1;
			OP_BYTE_REV: begin
				for (int i = 0; i < `STREAM_KEEP_BITS; i++) begin
					r = (r << 8) | 64'(w[8*i +: 8]);
				end
			end
			default:   r = w;
		endcase
		return r;
	endfunction

	task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
		$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
		errors++;
		test_errs++;
	endtask

	task automatic plain_error(input string what);
		$display("at %0t: %s", $time, what);
		errors++;
		test_errs++;
	endtask

	task automatic close_test();
		$display("test %0d finished: %0d beats, %0d errors", cur_id, test_beats, test_errs);
		test_beats = 0;
		test_errs  = 0;
	endtask

	initial begin
		errors    = 0;
		beats_out = 0;
		pending   = 0;
		in_pkt    = 1'b0;
		held      = 1'b0;
		cur_id    = 8'd1;
		cycle     = 0;
		tlast_out = 0;
		stall_cnt = 0;
		test_beats = 0;
		test_errs  = 0;
		prev_steady = 1'b0;
		prev_cycle  = 0;
		pkt_op    = OP_PASS;
	end

	always @(negedge aclk) begin
		if (!aresetn) begin
			if (m_tvalid !== 1'b0)
				value_error("m_tvalid", 64'd0, 64'(m_tvalid));
			if (s_tready !== 1'b0)
				value_error("s_tready", 64'd0, 64'(s_tready));
			if (pkt_count !== '0)
				value_error("pkt_count", 64'd0, 64'(pkt_count));
		end else if (exp_data_q.size() == 0 && pkt_count !== tlast_out[`STREAM_CNT_BITS-1:0]) begin
			value_error("pkt_count", 64'(tlast_out[`STREAM_CNT_BITS-1:0]), 64'(pkt_count));
		end
	end

	always @(posedge aresetn) begin
		close_test();
		cur_id = 8'd2;
	end

	always @(posedge aclk) begin
		cycle++;
		if (aresetn) begin
			if (s_tvalid && s_tready) begin
				// the opcode only counts on the first beat of a packet
				if (!in_pkt)
					pkt_op = op;
				in_pkt = !s_tlast;
				exp_data_q.push_back(expect_word(pkt_op, s_tdata));
				exp_keep_q.push_back(s_tkeep);
				exp_last_q.push_back(s_tlast);
				id_q.push_back(test_id);
				steady_q.push_back(steady);
				cycle_q.push_back(cycle);
			end
			if (held) begin
				if (!m_tvalid)
					plain_error("m_tvalid dropped while the output was stalled");
				else if (m_tdata !== held_data)
					value_error("m_tdata", held_data, m_tdata);
			end
			held      = m_tvalid && !m_tready;
			held_data = m_tdata;
			if (m_tvalid && m_tready) begin
				beats_out++;
				if (exp_data_q.size() == 0) begin
					plain_error("an output beat arrived with no input beat pending");
				end else begin
					if (id_q[0] != cur_id)
						close_test();
					cur_id = id_q.pop_front();
					test_beats++;
					if (exp_last_q[0])
						tlast_out++;
					if (m_tdata !== exp_data_q[0])
						value_error("m_tdata", exp_data_q[0], m_tdata);
					if (m_tkeep !== exp_keep_q[0])
						value_error("m_tkeep", 64'(exp_keep_q[0]), 64'(m_tkeep));
					if (m_tlast !== exp_last_q[0])
						value_error("m_tlast", 64'(exp_last_q[0]), 64'(m_tlast));
					if (steady_q[0] && steady && cycle - cycle_q[0] != 2)
						value_error("latency", 64'd2, 64'(cycle - cycle_q[0]));
					// a continuous input with m_tready high leaves no gap at the output
					if (steady_q[0] && prev_steady && cycle - prev_cycle != 1)
						value_error("beat spacing", 64'd1, 64'(cycle - prev_cycle));
					prev_steady = steady_q[0];
					prev_cycle  = cycle;
					void'(exp_data_q.pop_front());
					void'(exp_keep_q.pop_front());
					void'(exp_last_q.pop_front());
					void'(steady_q.pop_front());
					void'(cycle_q.pop_front());
				end
			end
			// with input pressure the path must push back within a few cycles
			if (!m_tready && s_tvalid)
				stall_cnt++;
			else
				stall_cnt = 0;
			if (stall_cnt > 8 && s_tready)
				plain_error("s_tready stayed high through a long output stall");
		end
		pending = exp_data_q.size();
	end

	always @(posedge done) begin
		close_test();
		if (exp_data_q.size() != 0)
			plain_error("input beats never appeared at the output");
		$display("test 5 finished: pkt_count %0d, tlast beats seen %0d", pkt_count, tlast_out);
	end

endmodule

// ==== verif/stream_path_tb.sv ====
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_path_tb;

	import stream_pkg::*;

	localparam int max_beats = 64;

	logic                         aclk;
	logic                         aresetn;
	stream_op_e                   op;
	logic                         s_tvalid;
	logic                         s_tready;
	logic [`STREAM_DATA_BITS-1:0] s_tdata;
	logic [`STREAM_KEEP_BITS-1:0] s_tkeep;
	logic                         s_tlast;
	logic                         m_tvalid;
	logic                         m_tready;
	logic [`STREAM_DATA_BITS-1:0] m_tdata;
	logic [`STREAM_KEEP_BITS-1:0] m_tkeep;
	logic                         m_tlast;
	logic [`STREAM_CNT_BITS-1:0]  pkt_count;

	stream_op_e                   tbl_op[max_beats];
	logic [`STREAM_DATA_BITS-1:0] tbl_data[max_beats];
	logic [`STREAM_KEEP_BITS-1:0] tbl_keep[max_beats];
	logic                         tbl_last[max_beats];
	logic [7:0]                   tbl_id[max_beats];
	int                           n_beats;
	logic                         table_ready;

	int         seed;
	int         stall_left;
	logic       bp_random;
	logic       steady;
	logic       done;
	logic [7:0] test_id;
	int         errors;
	int         beats_out;
	int         pending;
	int         accepted;
	int         last_first_num;
	logic       first;
	logic       taken;

	stream_path i_stream_path (
		.aclk(aclk), .aresetn(aresetn), .op(op),
		.s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata),
		.s_tkeep(s_tkeep), .s_tlast(s_tlast),
		.m_tvalid(m_tvalid), .m_tready(m_tready), .m_tdata(m_tdata),
		.m_tkeep(m_tkeep), .m_tlast(m_tlast), .pkt_count(pkt_count)
	);

	stream_path_checker i_checker (
		.aclk(aclk), .aresetn(aresetn), .op(op),
		.s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata),
		.s_tkeep(s_tkeep), .s_tlast(s_tlast),
		.m_tvalid(m_tvalid), .m_tready(m_tready), .m_tdata(m_tdata),
		.m_tkeep(m_tkeep), .m_tlast(m_tlast), .pkt_count(pkt_count),
		.test_id(test_id), .steady(steady), .done(done),
		.errors(errors), .beats_out(beats_out), .pending(pending)
	);

	always #10 aclk = ~aclk;

	task automatic add_beat(input stream_op_e code, input logic [63:0] data,
		input logic [7:0] keep, input logic last, input logic [7:0] id);
		tbl_op[n_beats]   = code;
		tbl_data[n_beats] = data;
		tbl_keep[n_beats] = keep;
		tbl_last[n_beats] = last;
		tbl_id[n_beats]   = id;
		n_beats++;
	endtask

	// later beats carry a different opcode, which the DUT must ignore
	task automatic add_packet(input stream_op_e code, input stream_op_e later_code,
		input int len, input logic [7:0] id);
		for (int b = 0; b < len; b++) begin
			add_beat((b == 0) ? code : later_code, {$random(seed), $random(seed)},
				8'hff, b == len - 1, id);
		end
	endtask

	// m_tready is held low for a fixed stall and is otherwise high about 70 percent of the time
	always @(negedge aclk) begin
		if (!bp_random) begin
			m_tready = 1'b1;
		end else if (stall_left > 0) begin
			m_tready = 1'b0;
			stall_left--;
		end else begin
			m_tready = (($random(seed) & 32'h7fffffff) % 10) < 7;
		end
	end

	initial begin
		wait (table_ready);
		#((n_beats * 20 + 200) * 20);
		$display("timeout: the run did not finish within %0d cycles", n_beats * 20 + 200);
		$display("Errors found");
		$finish;
	end

	initial begin
		aclk = 1'b0;
		aresetn = 1'b0;
		op = OP_PASS;
		s_tvalid = 1'b0;
		s_tdata = '0;
		s_tkeep = '0;
		s_tlast = 1'b0;
		m_tready = 1'b0;
		seed = 31671;
		stall_left = 0;
		bp_random = 1'b1;
		steady = 1'b0;
		done = 1'b0;
		test_id = 8'd2;
		n_beats = 0;
		accepted = 0;
		last_first_num = 0;
		first = 1'b1;
		table_ready = 1'b0;

		for (int k = 0; k < 4; k++)
			add_packet(stream_op_e'(2'(k)), stream_op_e'(2'(k + 1)), 3, 8'd2);
		add_beat(OP_INCR, 64'hffff_ffff_ffff_ffff, 8'h0f, 1'b1, 8'd2);
		for (int k = 0; k < 6; k++)
			add_packet(stream_op_e'(2'($random(seed))), stream_op_e'(2'($random(seed))),
				1 + (($random(seed) & 32'h7fffffff) % 4), 8'd3);
		add_packet(OP_INVERT, OP_INVERT, 10, 8'd4);
		add_packet(OP_BYTE_REV, OP_BYTE_REV, 8, 8'd6);
		table_ready = 1'b1;

		repeat (4) @(posedge aclk);
		@(negedge aclk);
		aresetn = 1'b1;

		for (int i = 0; i < n_beats; i++) begin
			@(negedge aclk);
			// op is sampled when the first beat leaves the op unit, so hold it till then
			if (tbl_op[i] != op) begin
				s_tvalid = 1'b0;
				while (beats_out < last_first_num)
					@(negedge aclk);
			end
			if (tbl_id[i] != test_id) begin
				test_id = tbl_id[i];
				if (test_id == 8'd4)
					stall_left = 10;
				if (test_id == 8'd6) begin
					// drain with m_tready high so every stage starts empty
					s_tvalid = 1'b0;
					bp_random = 1'b0;
					while (pending != 0)
						@(negedge aclk);
					repeat (2) @(negedge aclk);
					steady = 1'b1;
				end
			end
			op = tbl_op[i];
			s_tvalid = 1'b1;
			s_tdata = tbl_data[i];
			s_tkeep = tbl_keep[i];
			s_tlast = tbl_last[i];
			taken = 1'b0;
			while (!taken) begin
				taken = s_tready;
				@(posedge aclk);
				if (!taken)
					@(negedge aclk);
			end
			accepted++;
			if (first)
				last_first_num = accepted;
			first = tbl_last[i];
		end

		@(negedge aclk);
		s_tvalid = 1'b0;
		while (pending != 0)
			@(negedge aclk);
		repeat (4) @(negedge aclk);
		done = 1'b1;
		@(negedge aclk);
		$display("beats checked %0d, errors %0d", beats_out, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== stream_path.f ====
+incdir+common
common/stream_pkg.sv
verilog/axis_reg_slice.sv
verilog/stream_op_unit.sv
verilog/stream_path.sv
verif/stream_path_checker.sv
verif/stream_path_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the stream_path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	-f stream_path.f \
	--top-module stream_path_tb \
	-o stream_path_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/stream_path_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^No errors$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
